//--- design/fetchPkg.sv
package fetchPkg;

    // Instruction addresses count 32-bit words and not bytes
    localparam int AddrWidth = 32;

    // Width of one instruction word
    localparam int WordWidth = 32;

    // One cache block holds sixteen consecutive instruction words
    localparam int WordsPerBlock = 16;

    // Number of low address bits that pick a word inside a block
    localparam int OffsetWidth = $clog2(WordsPerBlock);

    // A whole block as it arrives from the memory controller in one fill strobe
    localparam int BlockWidth = WordsPerBlock * WordWidth;

    // The address with its word offset removed names a block in memory
    localparam int BlockAddrWidth = AddrWidth - OffsetWidth;

    // Word address as carried around the fetch stage
    typedef logic [AddrWidth-1:0] addrT;

    // Block request toward the memory controller
    // Valid is a single-cycle strobe and there is no back-pressure
    typedef struct packed {
        logic                      valid;
        logic [BlockAddrWidth-1:0] blockAddr;
    } memReqT;

    // Block fill from the memory controller
    // Word i of the block sits at data[32*i +: 32]
    typedef struct packed {
        logic                  valid;
        logic [BlockWidth-1:0] data;
    } memFillT;

    // States of the refill FSM in fetchControl
    // Idle waits for a miss, Wait waits for the fill strobe and
    // Fill is the single cycle in which the freshly written line hits
    typedef enum logic [1:0] {
        Idle,
        Wait,
        Fill
    } refillStateT;

endpackage

//--- design/fetchControl.sv
`timescale 1ns/1ps

module fetchControl #(
    parameter fetchPkg::addrT ResetPc = '0
) (
    input  logic              clk,
    input  logic              rst,

    // Level stalls from the rest of the pipeline
    input  logic              halt,
    input  logic              stallDma,
    input  logic              blockInstr,

    // Address the pipeline wants fetched next
    input  fetchPkg::addrT    nextPc,

    // Lookup result of the instruction cache for the current PC
    input  logic              hit,

    // Fill strobe from the memory controller
    input  fetchPkg::memFillT memFill,

    output fetchPkg::addrT    fetchAddr,
    output fetchPkg::addrT    pcPlus1,
    output fetchPkg::memReqT  memReq,
    output logic              fillEn,
    output fetchPkg::addrT    fillAddr
);

    // Program counter
    fetchPkg::addrT pc;

    // Refill FSM state
    fetchPkg::refillStateT state;
    fetchPkg::refillStateT stateNext;

    // Stall sources
    logic extStall;
    logic miss;
    logic stall;

    // High in the one Idle cycle that turns a miss into a request
    logic startMiss;

    // Registered request strobe
    logic reqValid;

    // PC of the miss being serviced, kept until the fill is written
    fetchPkg::addrT missAddr;

    // Any stall coming from outside the fetch stage
    assign extStall = halt | stallDma | blockInstr;

    // A PC that does not hit in the cache is treated as a stall until the
    // refill lands and the same PC hits
    assign miss  = ~hit;
    assign stall = extStall | miss;

    // The PC loads nextPc on every edge unless some stall holds it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= ResetPc;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

    assign fetchAddr = pc;

    // Sequential successor of the current PC
    // Addresses are word addresses, so the step is one
    assign pcPlus1 = pc + fetchPkg::addrT'(1);

    // A request goes out only from Idle and only while nothing outside
    // holds the pipeline
    // A halted stage does not fetch, so a miss under halt waits quietly
    assign startMiss = (state == fetchPkg::Idle) && miss && !extStall;

    // Next-state logic of the refill FSM
    always_comb begin
        stateNext = state;
        case (state)
            fetchPkg::Idle: begin
                if (startMiss) begin
                    stateNext = fetchPkg::Wait;
                end
            end
            fetchPkg::Wait: begin
                // The fill strobe lasts one cycle, so it must be caught here
                if (memFill.valid) begin
                    stateNext = fetchPkg::Fill;
                end
            end
            fetchPkg::Fill: begin
                // The line was written at the last edge and hits now
                stateNext = fetchPkg::Idle;
            end
            default: begin
                stateNext = fetchPkg::Idle;
            end
        endcase
    end

    // State register and request strobe
    // The strobe is high for exactly the first cycle spent in Wait, so a
    // miss that is held across many cycles sends a single request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= fetchPkg::Idle;
            reqValid <= 1'b0;
        end else begin
            state    <= stateNext;
            reqValid <= startMiss;
        end
    end

    // Capture the missed PC when the request is launched
    // It stays stable through Wait, which is all the fill needs
    always_ff @(posedge clk) begin
        if (startMiss) begin
            missAddr <= pc;
        end
    end

    // The request names the block, so the word offset is dropped
    assign memReq.valid     = reqValid;
    assign memReq.blockAddr = missAddr[fetchPkg::AddrWidth-1:fetchPkg::OffsetWidth];

    // Write the cache on the fill strobe, only while a request is open
    assign fillEn   = (state == fetchPkg::Wait) && memFill.valid;
    assign fillAddr = missAddr;

endmodule

//--- design/instrCache.sv
`timescale 1ns/1ps

module instrCache #(
    parameter int NumLines = 16
) (
    input  logic                            clk,
    input  logic                            rst,

    // Lookup side, driven by the PC
    input  fetchPkg::addrT                  fetchAddr,

    // Fill side, driven by the refill FSM and the memory controller
    input  logic                            fillEn,
    input  fetchPkg::addrT                  fillAddr,
    input  logic [fetchPkg::BlockWidth-1:0] fillData,

    output logic [fetchPkg::WordWidth-1:0]  instr,
    output logic                            hit
);

    // Index bits select one of the lines
    // NumLines is a power of two between 2 and 256
    localparam int IndexWidth = $clog2(NumLines);

    // Everything above offset and index is kept as the tag
    localparam int TagWidth = fetchPkg::AddrWidth - fetchPkg::OffsetWidth - IndexWidth;

    // One cache line without its valid bit
    // The words field views the block as an array so that word i is
    // words[i], the same slice the memory controller uses
    typedef struct packed {
        logic [TagWidth-1:0]                                         tag;
        logic [fetchPkg::WordsPerBlock-1:0][fetchPkg::WordWidth-1:0] words;
    } lineT;

    // One valid bit for each line
    logic [NumLines-1:0] lineValid;

    // Tag and data storage
    lineT lines [NumLines];

    // Lookup address split
    logic [fetchPkg::OffsetWidth-1:0] rdOffset;
    logic [IndexWidth-1:0]            rdIndex;
    logic [TagWidth-1:0]              rdTag;

    // Fill address split
    // The word offset of the fill address does not matter, the whole block
    // is written at once
    logic [IndexWidth-1:0]            wrIndex;
    logic [TagWidth-1:0]              wrTag;

    // Line selected by the lookup index
    lineT rdLine;

    assign rdOffset = fetchAddr[fetchPkg::OffsetWidth-1:0];
    assign rdIndex  = fetchAddr[fetchPkg::OffsetWidth +: IndexWidth];
    assign rdTag    = fetchAddr[fetchPkg::AddrWidth-1 -: TagWidth];

    assign wrIndex  = fillAddr[fetchPkg::OffsetWidth +: IndexWidth];
    assign wrTag    = fillAddr[fetchPkg::AddrWidth-1 -: TagWidth];

    // Lookup is purely combinational so a hitting PC gets its
    // instruction in the same cycle
    assign rdLine = lines[rdIndex];

    // A hit needs a valid line whose stored tag matches the PC
    assign hit = lineValid[rdIndex] && (rdLine.tag == rdTag);

    // Word select by the offset bits
    // The value only means something while hit is high
    assign instr = rdLine.words[rdOffset];

    // Valid bits
    // A fill marks its line valid whatever was there before
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lineValid <= '0;
        end else if (fillEn) begin
            lineValid[wrIndex] <= 1'b1;
        end
    end

    // Tag and data write
    // Direct mapping means a fill simply overwrites the indexed line,
    // which evicts any older block that shared the index
    always_ff @(posedge clk) begin
        if (fillEn) begin
            lines[wrIndex].tag   <= wrTag;
            lines[wrIndex].words <= fillData;
        end
    end

endmodule

//--- design/fetchStage.sv
`timescale 1ns/1ps

module fetchStage #(
    parameter int             NumLines = 16,
    parameter fetchPkg::addrT ResetPc  = '0
) (
    input  logic                           clk,
    input  logic                           rst,

    // Level stalls from halt, the data-side DMA and decode
    input  logic                           halt,
    input  logic                           stallDma,
    input  logic                           blockInstr,

    // Next fetch address chosen by the pipeline
    input  fetchPkg::addrT                 nextPc,

    // Block fill from the memory controller
    input  fetchPkg::memFillT              memFill,

    output logic [fetchPkg::WordWidth-1:0] instr,
    output logic                           instrValid,
    output fetchPkg::addrT                 pcPlus1,
    output fetchPkg::memReqT               memReq
);

    // Current PC presented to the cache
    fetchPkg::addrT fetchAddr;

    // Cache lookup result
    logic hit;

    // Cache write port, controlled by the refill FSM
    logic           fillEn;
    fetchPkg::addrT fillAddr;

    // PC, stall logic and refill FSM
    fetchControl #(
        .ResetPc    (ResetPc)
    ) fetchControl_i (
        .clk        (clk),
        .rst        (rst),
        .halt       (halt),
        .stallDma   (stallDma),
        .blockInstr (blockInstr),
        .nextPc     (nextPc),
        .hit        (hit),
        .memFill    (memFill),
        .fetchAddr  (fetchAddr),
        .pcPlus1    (pcPlus1),
        .memReq     (memReq),
        .fillEn     (fillEn),
        .fillAddr   (fillAddr)
    );

    // Direct-mapped instruction cache
    // The fill data goes straight from the memory controller to the cache
    instrCache #(
        .NumLines  (NumLines)
    ) instrCache_i (
        .clk       (clk),
        .rst       (rst),
        .fetchAddr (fetchAddr),
        .fillEn    (fillEn),
        .fillAddr  (fillAddr),
        .fillData  (memFill.data),
        .instr     (instr),
        .hit       (hit)
    );

    // An instruction is valid exactly when the current PC hits
    assign instrValid = hit;

endmodule

//--- sim/fetchChecker.sv
`timescale 1ns/1ps

module fetchChecker #(
    parameter int NumLines = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           halt,
    input  logic                           stallDma,
    input  logic                           blockInstr,
    input  fetchPkg::addrT                 nextPc,
    input  fetchPkg::memFillT              memFill,
    input  logic [fetchPkg::WordWidth-1:0] instr,
    input  logic                           instrValid,
    input  fetchPkg::addrT                 pcPlus1,
    input  fetchPkg::memReqT               memReq,
    output int                             valueErrors,
    output int                             protocolErrors,
    output int                             reqCount,
    output int                             instrCount
);

    localparam int IndexWidth = $clog2(NumLines);
    localparam int TagShift   = fetchPkg::OffsetWidth + IndexWidth;

    // Which block each line should hold, following direct mapping
    logic [NumLines-1:0] modelValid;
    fetchPkg::addrT      modelTag [NumLines];

    // A request has gone out and its fill has not come back yet
    logic                                outstanding;
    logic [fetchPkg::BlockAddrWidth-1:0] reqBlock;

    // What the previous cycle implies for this one
    logic           prevStall;
    logic           prevCanReq;
    fetchPkg::addrT prevPcPlus1;
    fetchPkg::addrT prevNextPc;

    // Values for the cycle being checked
    fetchPkg::addrT        pc;
    logic [IndexWidth-1:0] idx;
    logic [IndexWidth-1:0] fillIdx;
    logic                  expHit;
    logic                  extStall;

    initial begin
        valueErrors    = 0;
        protocolErrors = 0;
        reqCount       = 0;
        instrCount     = 0;
    end

    // Instruction word that memory holds at word address a
    function automatic logic [31:0] expectedWord(input fetchPkg::addrT a);
        return (a ^ 32'hA5C3_0000) + (a << 8);
    endfunction

    task automatic reportValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("[ERROR] %s expected %h actual %h at %0t", name, expected, actual, $time);
        valueErrors++;
    endtask

    // Outputs are combinational from the PC and inputs change 2 ns after the
    // rising edge, so the falling edge sees everything settled
    always @(negedge clk) begin
        if (rst) begin
            if (instrValid !== 1'b0) reportValue("resetInstrValid", 32'd0, 32'(instrValid));
            if (memReq.valid !== 1'b0) reportValue("resetReqValid", 32'd0, 32'(memReq.valid));
            modelValid  = '0;
            outstanding = 1'b0;
            // Reset holds the PC just like a stall
            prevStall   = 1'b1;
            prevCanReq  = 1'b0;
            prevPcPlus1 = pcPlus1;
            prevNextPc  = nextPc;
        end else begin
            pc       = pcPlus1 - 1;
            idx      = pc[fetchPkg::OffsetWidth +: IndexWidth];
            expHit   = modelValid[idx] && (modelTag[idx] == (pc >> TagShift));
            extStall = halt | stallDma | blockInstr;

            // A held PC keeps pcPlus1, otherwise the PC took last cycle's nextPc
            if (prevStall) begin
                if (pcPlus1 !== prevPcPlus1) reportValue("stallHold", prevPcPlus1, pcPlus1);
            end else if (pcPlus1 !== prevNextPc + 1) begin
                reportValue("pcLoad", prevNextPc + 1, pcPlus1);
            end

            if (instrValid !== expHit) reportValue("hitState", 32'(expHit), 32'(instrValid));
            if (instrValid === 1'b1) begin
                instrCount++;
                if (instr !== expectedWord(pc)) reportValue("instrWord", expectedWord(pc), instr);
            end

            // One strobe, the cycle after an unstalled Idle miss
            if (memReq.valid !== prevCanReq) begin
                reportValue("reqStrobe", 32'(prevCanReq), 32'(memReq.valid));
            end
            if (memReq.valid === 1'b1) begin
                reqCount++;
                if (memReq.blockAddr !== pc[fetchPkg::AddrWidth-1:fetchPkg::OffsetWidth]) begin
                    reportValue("reqBlockAddr", 32'(pc >> fetchPkg::OffsetWidth),
                                32'(memReq.blockAddr));
                end
                if (outstanding) begin
                    $display("A second request went out while a refill was still open");
                    protocolErrors++;
                end
                outstanding = 1'b1;
                reqBlock    = memReq.blockAddr;
            end

            // An open request blocks a new one, including in its own fill cycle
            prevCanReq = !expHit && !outstanding && !extStall;

            if (memFill.valid === 1'b1) begin
                if (!outstanding) begin
                    $display("A fill strobe arrived with no open request at %0t", $time);
                    protocolErrors++;
                end else begin
                    // The line is written at the coming edge and may evict another block
                    fillIdx             = reqBlock[IndexWidth-1:0];
                    modelValid[fillIdx] = 1'b1;
                    modelTag[fillIdx]   = fetchPkg::addrT'(reqBlock) >> IndexWidth;
                    outstanding         = 1'b0;
                end
            end

            prevStall   = extStall || !expHit;
            prevPcPlus1 = pcPlus1;
            prevNextPc  = nextPc;
        end
    end

endmodule

//--- sim/fetchTb.sv
`timescale 1ns/1ps

module fetchTb;

    localparam int             NumLines = 16;
    localparam fetchPkg::addrT ResetPc  = 32'h0000_0038;

    localparam int NumRows      = 12;
    localparam int JumpTimeout  = 40;
    localparam int DrainTimeout = 40;
    localparam int MinRequests  = 6;
    localparam int MinInstrs    = 40;

    // Seq follows pcPlus1, Jump loads a target first, and Stall offers an
    // unrelated target that must never be taken
    typedef enum logic [1:0] {
        Seq,
        Jump,
        Stall
    } modeT;

    // Mask bits are {halt, stallDma, blockInstr}
    typedef struct packed {
        modeT           mode;
        fetchPkg::addrT target;
        logic [2:0]     mask;
        logic [7:0]     cycles;
    } stimRowT;

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           halt;
    logic                           stallDma;
    logic                           blockInstr;
    fetchPkg::addrT                 nextPc;
    fetchPkg::memFillT              memFill;
    logic [fetchPkg::WordWidth-1:0] instr;
    logic                           instrValid;
    fetchPkg::addrT                 pcPlus1;
    fetchPkg::memReqT               memReq;

    stimRowT rows [NumRows];

    // Memory controller model state
    logic [15:0]                         lfsr = 16'd11396;
    logic [2:0]                          delay;
    int                                  bitIdx;
    int                                  pendCount = 0;
    logic [fetchPkg::BlockAddrWidth-1:0] pendBlock;

    int row;
    int timeouts;
    int failures;
    int valueErrors;
    int protocolErrors;
    int reqCount;
    int instrCount;

    fetchStage #(
        .NumLines   (NumLines),
        .ResetPc    (ResetPc)
    ) fetchStage_i (
        .clk        (clk),
        .rst        (rst),
        .halt       (halt),
        .stallDma   (stallDma),
        .blockInstr (blockInstr),
        .nextPc     (nextPc),
        .memFill    (memFill),
        .instr      (instr),
        .instrValid (instrValid),
        .pcPlus1    (pcPlus1),
        .memReq     (memReq)
    );

    fetchChecker #(
        .NumLines       (NumLines)
    ) fetchChecker_i (
        .clk            (clk),
        .rst            (rst),
        .halt           (halt),
        .stallDma       (stallDma),
        .blockInstr     (blockInstr),
        .nextPc         (nextPc),
        .memFill        (memFill),
        .instr          (instr),
        .instrValid     (instrValid),
        .pcPlus1        (pcPlus1),
        .memReq         (memReq),
        .valueErrors    (valueErrors),
        .protocolErrors (protocolErrors),
        .reqCount       (reqCount),
        .instrCount     (instrCount)
    );

    always #10 clk = ~clk;

    // Right-shifting Galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    // Memory contents, word i of the block at data[32*i +: 32]
    function automatic logic [fetchPkg::BlockWidth-1:0] buildBlock(
        input logic [fetchPkg::BlockAddrWidth-1:0] blockAddr
    );
        logic [fetchPkg::BlockWidth-1:0] block;
        fetchPkg::addrT                  a;
        int                              i;
        block = '0;
        for (i = 0; i < fetchPkg::WordsPerBlock; i++) begin
            a = {blockAddr, 4'(i)};
            block[32*i +: 32] = (a ^ 32'hA5C3_0000) + (a << 8);
        end
        return block;
    endfunction

    // Each request gets a latency of 1 to 8 cycles from three LFSR bits
    always @(negedge clk) begin
        if (!rst && memReq.valid) begin
            delay = '0;
            for (bitIdx = 0; bitIdx < 3; bitIdx++) begin
                delay = {delay[1:0], lfsr[0]};
                lfsr  = lfsrStep(lfsr);
            end
            pendBlock = memReq.blockAddr;
            pendCount = int'(delay) + 1;
        end
    end

    // Fill strobe lasts one cycle
    always @(posedge clk) begin
        #2;
        memFill.valid = 1'b0;
        if (pendCount > 0) begin
            pendCount = pendCount - 1;
            if (pendCount == 0) begin
                memFill.data  = buildBlock(pendBlock);
                memFill.valid = 1'b1;
            end
        end
    end

    task automatic loadRows();
        rows[0]  = '{Seq,   32'h0000_0000, 3'b000, 8'd60};
        rows[1]  = '{Stall, 32'h0000_0200, 3'b100, 8'd6};
        rows[2]  = '{Stall, 32'h0000_0300, 3'b010, 8'd5};
        rows[3]  = '{Stall, 32'h0000_0400, 3'b001, 8'd5};
        rows[4]  = '{Jump,  32'h0000_0123, 3'b000, 8'd20};
        // Same index as block 3 with another tag, then back to block 3
        rows[5]  = '{Jump,  32'h0000_1036, 3'b000, 8'd12};
        rows[6]  = '{Jump,  32'h0000_003C, 3'b000, 8'd10};
        // DMA stall lands on the missing PC before its request can go out
        rows[7]  = '{Jump,  32'h0000_2340, 3'b010, 8'd4};
        rows[8]  = '{Seq,   32'h0000_0000, 3'b101, 8'd3};
        rows[9]  = '{Seq,   32'h0000_0000, 3'b000, 8'd30};
        // The PC wraps past the top of the address space
        rows[10] = '{Jump,  32'hFFFF_FFFC, 3'b000, 8'd14};
        rows[11] = '{Jump,  32'h0000_0045, 3'b000, 8'd8};
    endtask

    // Called 2 ns after a rising edge and returns at the same point of the next cycle
    task automatic driveCycle(input logic [2:0] mask, input fetchPkg::addrT addr);
        {halt, stallDma, blockInstr} = mask;
        nextPc = addr;
        @(posedge clk);
        #2;
    endtask

    // Hold the target until the PC has taken it, which waits out any open miss
    task automatic jumpTo(input fetchPkg::addrT target);
        int t;
        {halt, stallDma, blockInstr} = 3'b000;
        nextPc = target;
        for (t = 0; t < JumpTimeout; t++) begin
            @(posedge clk);
            #2;
            if (pcPlus1 == fetchPkg::addrT'(target + 1)) break;
        end
        if (t == JumpTimeout) begin
            $display("Timeout: the PC never loaded the jump target %h", target);
            timeouts++;
        end
    endtask

    task automatic applyRow(input stimRowT r);
        int n;
        if (r.mode == Jump) begin
            jumpTo(r.target);
        end
        for (n = 0; n < int'(r.cycles); n++) begin
            if (r.mode == Stall) begin
                driveCycle(r.mask, r.target);
            end else begin
                driveCycle(r.mask, pcPlus1);
            end
        end
    endtask

    task automatic waitForHit();
        int t;
        for (t = 0; t < DrainTimeout; t++) begin
            if (instrValid) break;
            driveCycle(3'b000, pcPlus1);
        end
        if (t == DrainTimeout) begin
            $display("Timeout: the last fetch never produced a valid instruction");
            timeouts++;
        end
    endtask

    initial begin
        rst        = 1'b1;
        halt       = 1'b0;
        stallDma   = 1'b0;
        blockInstr = 1'b0;
        nextPc     = ResetPc;
        memFill    = '0;
        timeouts   = 0;
        loadRows();
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        for (row = 0; row < NumRows && timeouts == 0; row++) begin
            applyRow(rows[row]);
        end
        if (timeouts == 0) begin
            waitForHit();
        end
        failures = valueErrors + protocolErrors + timeouts;
        if (reqCount < MinRequests || instrCount < MinInstrs) begin
            $display("Too little activity: %0d requests and %0d instructions seen",
                     reqCount, instrCount);
            failures++;
        end
        $display("Errors: %0d value, %0d protocol, %0d timeouts; %0d requests, %0d instructions",
                 valueErrors, protocolErrors, timeouts, reqCount, instrCount);
        if (failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
design/fetchPkg.sv
design/fetchControl.sv
design/instrCache.sv
design/fetchStage.sv
sim/fetchChecker.sv
sim/fetchTb.sv

//--- run.sh
#!/bin/sh
# Compile the fetch stage and its testbench with Verilator, run it,
# and decide pass or fail from the simulation log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module fetchTb -f filelist.f -o fetchSim \
    && ./obj_dir/fetchSim > sim.log 2>&1 \
    || { echo "Build or simulation run did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -q "Simulation PASSED" sim.log \
    && { echo "run.sh: test passed"; exit 0; } \
    || { echo "run.sh: test failed"; exit 1; }
